/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_cmd
RTL_TOP   ?= uart_cmd_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= uart_pkg.sv cmd_pkg.sv uart_tx.sv uart_rx.sv cmd_master.sv uart_cmd_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx 'TEST OK' $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
uart_pkg.sv
cmd_pkg.sv
uart_tx.sv
uart_rx.sv
cmd_master.sv
uart_cmd_top.sv
tb_clk_gen.sv
tb_uart_cmd.sv

/* cmd_master.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_master
  import uart_pkg::*, cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT     = 434,
  parameter int GAP_BITS         = 15,
  parameter int RSP_TIMEOUT_BITS = 40
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_req,
  input  cmd_t        cmd,
  output logic        cmd_ack,
  output rsp_t        rsp,
  output logic        tx_start,
  output logic [7:0]  tx_byte,
  input  logic        tx_busy,
  output logic        rx_arm,
  input  logic        rx_done,
  input  uart_frame_t rx_frame
);

  localparam int CNT_W    = $clog2(CLKS_PER_BIT);
  localparam int MAX_BITS = (GAP_BITS > RSP_TIMEOUT_BITS) ? GAP_BITS : RSP_TIMEOUT_BITS;
  localparam int BITS_W   = $clog2(MAX_BITS + 1);

  typedef enum logic [3:0] {
    s_idle,
    s_send_addr,
    s_wait_addr,
    s_gap,
    s_send_data,
    s_wait_data,
    s_wait_reply,
    s_ack,
    s_release
  } state_e;

  state_e            state;
  cmd_t              cmd_q;
  logic [CNT_W-1:0]  clk_cnt;
  logic [BITS_W-1:0] bit_cnt;
  logic              bit_tick;
  logic              gap_done;
  logic              timeout;

  function automatic rsp_status_e map_status(input rx_error_e err);
    case (err)
      rx_err_parity: map_status = st_parity_err;
      rx_err_frame:  map_status = st_frame_err;
      default:       map_status = st_ok;
    endcase
  endfunction

  assign bit_tick = clk_cnt == CNT_W'(CLKS_PER_BIT - 1);
  assign gap_done = bit_tick && (bit_cnt == BITS_W'(GAP_BITS - 1));
  assign timeout  = bit_tick && (bit_cnt == BITS_W'(RSP_TIMEOUT_BITS - 1));

  // the start pulse lasts one cycle since the send states move on as soon as it fires
  assign tx_start = ((state == s_send_addr) || (state == s_send_data)) && !tx_busy;
  assign tx_byte  = (state == s_send_data) ? cmd_q.wdata : {cmd_q.op == op_write, cmd_q.addr};

  // shared bit timer for the write gap and the reply window
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if ((state != s_gap) && (state != s_wait_reply))
    begin
      clk_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (bit_tick)
    begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + BITS_W'(1);
    end
    else
    begin
      clk_cnt <= clk_cnt + CNT_W'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == s_idle && cmd_req)
      cmd_q <= cmd;  // sampled once, at acceptance
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transaction FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= s_idle;
      cmd_ack <= 1'b0;
      rx_arm  <= 1'b0;
      rsp     <= '0;
    end
    else
    begin
      case (state)
        s_idle:
          if (cmd_req)
            state <= s_send_addr;
        s_send_addr:
          if (!tx_busy)
            state <= s_wait_addr;
        s_wait_addr:
        begin
          if (!tx_busy)
          begin
            if (cmd_q.op == op_write)
              state <= s_gap;
            else
            begin
              rx_arm <= 1'b1;
              state  <= s_wait_reply;
            end
          end
        end
        s_gap:
          if (gap_done)
            state <= s_send_data;
        s_send_data:
          if (!tx_busy)
            state <= s_wait_data;
        s_wait_data:
        begin
          if (!tx_busy)
          begin
            rsp     <= '{status: st_ok, rdata: 8'h00};
            cmd_ack <= 1'b1;
            state   <= s_ack;
          end
        end
        s_wait_reply:
        begin
          // a reply still in flight when the window closes is dropped with the arm
          if (rx_done)
          begin
            rsp     <= '{status: map_status(rx_frame.err), rdata: rx_frame.data};
            cmd_ack <= 1'b1;
            rx_arm  <= 1'b0;
            state   <= s_ack;
          end
          else if (timeout)
          begin
            rsp     <= '{status: st_timeout, rdata: 8'h00};
            cmd_ack <= 1'b1;
            rx_arm  <= 1'b0;
            state   <= s_ack;
          end
        end
        s_ack:
        begin
          if (!cmd_req)
          begin
            cmd_ack <= 1'b0;
            state   <= s_release;
          end
        end
        s_release:
          state <= s_idle;  // one quiet cycle before the next request is taken
        default:
          state <= s_idle;
      endcase
    end
  end

  // four-phase rule, the host has to let go of the request first
  a_ack_after_req_low : assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(cmd_ack) |-> $past(!cmd_req)
  );

endmodule

`default_nettype wire

/* cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

  // bit 15 of the host command word
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cmd_op_e;

  typedef struct packed {
    cmd_op_e    op;     // bit 15
    logic [6:0] addr;   // bits 14 to 8
    logic [7:0] wdata;  // bits 7 to 0, don't care on reads
  } cmd_t;

  typedef enum logic [1:0] {
    st_ok         = 2'd0,
    st_parity_err = 2'd1,
    st_frame_err  = 2'd2,
    st_timeout    = 2'd3
  } rsp_status_e;

  // rdata stays zero for writes and timeouts
  typedef struct packed {
    rsp_status_e status;
    logic [7:0]  rdata;
  } rsp_t;

endpackage

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 10,
  parameter int RESET_CYCLES   = 5
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // released away from the DUT's active edge
  end

endmodule

`default_nettype wire

/* tb_uart_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd
  import cmd_pkg::*;
();

  localparam int CPB              = 8;
  localparam int PARITY_ODD       = 0;
  localparam int GAP_BITS         = 15;
  localparam int RSP_TIMEOUT_BITS = 40;
  localparam int FRAME_CLKS       = 11 * CPB;
  localparam int WAIT_LIMIT       = 2000;  // longest any single wait may take in cycles

  typedef enum logic [1:0] {
    reply_good,
    reply_bad_parity,
    reply_low_stop,
    reply_none
  } reply_e;

  logic        clk;
  logic        rst_n;
  logic        cmd_req;
  cmd_t        cmd;
  logic        cmd_ack;
  rsp_t        rsp;
  logic        rx;
  logic        tx;
  int          cyc        = 0;
  logic [31:0] lfsr       = 32'hc3c9_0d94;
  int          checks     = 0;
  int          mismatches = 0;
  int          faults     = 0;

  tb_clk_gen i_clk_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  uart_cmd_top #(
    .CLKS_PER_BIT    (CPB),
    .PARITY_ODD      (PARITY_ODD),
    .GAP_BITS        (GAP_BITS),
    .RSP_TIMEOUT_BITS(RSP_TIMEOUT_BITS)
  ) i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .cmd_req(cmd_req),
    .cmd    (cmd),
    .cmd_ack(cmd_ack),
    .rsp    (rsp),
    .rx     (rx),
    .tx     (tx)
  );

  always @(posedge clk)
    cyc <= cyc + 1;  // time stamps for the serial line

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_step(lfsr);
      b[i] = lfsr[31];
    end
  endtask

  // the parity bit makes the ones count over data and parity even, or odd when odd is chosen
  function automatic logic expected_parity(input logic [7:0] d);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += int'(d[i]);
    expected_parity = ((ones % 2) == 1) != (PARITY_ODD != 0);
  endfunction

  function automatic string status_text(input rsp_status_e s);
    case (s)
      st_ok:         status_text = "ok";
      st_parity_err: status_text = "parity_err";
      st_frame_err:  status_text = "frame_err";
      default:       status_text = "timeout";
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_rsp(input string name, input rsp_t exp, input rsp_t act);
    checks++;
    if (act !== exp)
    begin
      mismatches++;
      $display("Fail %s: expected rsp %s/%02h, actual %s/%02h", name,
               status_text(exp.status), exp.rdata, status_text(act.status), act.rdata);
    end
  endtask

  task automatic check_frame(input string name, input logic [7:0] exp, input logic [7:0] act,
                             input logic par_ok);
    checks++;
    if (act !== exp || par_ok !== 1'b1)
    begin
      mismatches++;
      $display("Fail %s: expected byte %02h with good parity, actual %02h with %s parity",
               name, exp, act, par_ok ? "good" : "bad");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      mismatches++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_window(input string name, input int lo, input int hi, input int act);
    checks++;
    if (act < lo || act > hi)
    begin
      mismatches++;
      $display("Fail %s: expected %0d to %0d cycles, actual %0d", name, lo, hi, act);
    end
  endtask

  task automatic report_fault(input string msg);
    faults++;
    $display("%s", msg);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic issue_cmd(input cmd_t c);
    @(negedge clk);
    cmd     = c;
    cmd_req = 1'b1;
  endtask

  task automatic wait_ack(input string name, output int ack_cyc);
    int n;
    n = 0;
    while (cmd_ack !== 1'b1 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_ack !== 1'b1)
      report_fault({name, ": cmd_ack never rose"});
    ack_cyc = cyc;
  endtask

  task automatic drop_req(input string name);
    int n;
    cmd_req = 1'b0;  // always entered on a falling edge
    n       = 0;
    while (cmd_ack !== 1'b0 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_ack !== 1'b0)
      report_fault({name, ": cmd_ack stayed high after cmd_req dropped"});
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // serial slave model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic decode_frame(input string name, output logic [7:0] data,
                              output logic par_ok, output logic stop_ok, output int fall_cyc);
    int   n;
    logic par;
    data     = '0;
    par_ok   = 1'b0;
    stop_ok  = 1'b0;
    fall_cyc = cyc;
    n        = 0;
    while (tx !== 1'b0 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0)
      report_fault({name, ": no start bit appeared on tx"});
    else
    begin
      fall_cyc = cyc;
      repeat (CPB / 2) @(negedge clk);
      if (tx !== 1'b0)
        report_fault({name, ": start bit on tx was gone by its middle"});
      for (int i = 0; i < 8; i++)
      begin
        repeat (CPB) @(negedge clk);
        data[i] = tx;  // lsb first
      end
      repeat (CPB) @(negedge clk);
      par = tx;
      repeat (CPB) @(negedge clk);
      stop_ok = tx;
      par_ok  = par == expected_parity(data);
    end
  endtask

  task automatic send_reply(input logic [7:0] data, input logic flip_parity,
                            input logic low_stop);
    logic [10:0] bits;
    bits = {~low_stop, expected_parity(data) ^ flip_parity, data, 1'b0};
    repeat (CPB) @(negedge clk);  // one bit of turnaround lets the receiver arm first
    for (int i = 0; i < 11; i++)
    begin
      rx = bits[i];
      repeat (CPB) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic watch_idle_line(input string name, input int cycles);
    logic stayed_high;
    stayed_high = 1'b1;
    repeat (cycles)
    begin
      @(negedge clk);
      if (tx !== 1'b1)
        stayed_high = 1'b0;
    end
    check_bit({name, " tx idle"}, 1'b1, stayed_high);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reset_values();
    int n;
    @(negedge clk);
    check_bit("reset tx", 1'b1, tx);
    check_bit("reset cmd_ack", 1'b0, cmd_ack);
    check_rsp("reset rsp", '0, rsp);
    n = 0;
    while (rst_n !== 1'b1 && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1)
      report_fault("reset was never released");
    repeat (4)
    begin
      @(negedge clk);
      check_bit("after reset tx", 1'b1, tx);
      check_bit("after reset cmd_ack", 1'b0, cmd_ack);
      check_rsp("after reset rsp", '0, rsp);
    end
  endtask

  task automatic write_cycle(input string name, input logic [6:0] addr, input int hold);
    cmd_t       c;
    rsp_t       held;
    logic [7:0] wdata;
    logic [7:0] d0;
    logic [7:0] d1;
    logic       p0, p1, s0, s1;
    int         f0, f1, ack_cyc;
    logic       steady;
    random_byte(wdata);
    c = '{op: op_write, addr: addr, wdata: wdata};
    issue_cmd(c);
    fork
      begin
        decode_frame({name, " addr"}, d0, p0, s0, f0);
        decode_frame({name, " data"}, d1, p1, s1, f1);
      end
      wait_ack(name, ack_cyc);
    join
    check_frame({name, " addr frame"}, {1'b1, addr}, d0, p0);
    check_bit({name, " addr stop bit"}, 1'b1, s0);
    check_frame({name, " data frame"}, wdata, d1, p1);
    check_bit({name, " data stop bit"}, 1'b1, s1);
    check_window({name, " gap"}, GAP_BITS * CPB, (GAP_BITS + 2) * CPB, f1 - (f0 + FRAME_CLKS));
    check_rsp(name, '{status: st_ok, rdata: 8'h00}, rsp);
    held   = rsp;
    steady = 1'b1;
    repeat (hold)
    begin
      @(negedge clk);
      if (cmd_ack !== 1'b1 || rsp !== held || tx !== 1'b1)
        steady = 1'b0;
    end
    if (hold > 0)
      check_bit({name, " ack, rsp and tx held"}, 1'b1, steady);
    drop_req(name);
    watch_idle_line({name, " after ack"}, FRAME_CLKS);  // nothing past the data frame
  endtask

  task automatic read_cycle(input string name, input logic [6:0] addr, input reply_e mode);
    cmd_t       c;
    rsp_t       exp;
    logic [7:0] reply;
    logic [7:0] d0;
    logic       p0, s0;
    int         f0, ack_cyc;
    random_byte(reply);
    c = '{op: op_read, addr: addr, wdata: 8'h5a};  // wdata has no meaning on a read
    issue_cmd(c);
    fork
      begin
        decode_frame({name, " addr"}, d0, p0, s0, f0);
        if (mode != reply_none)
          send_reply(reply, mode == reply_bad_parity, mode == reply_low_stop);
      end
      wait_ack(name, ack_cyc);
    join
    check_frame({name, " addr frame"}, {1'b0, addr}, d0, p0);
    check_bit({name, " addr stop bit"}, 1'b1, s0);
    case (mode)
      reply_good:       exp = '{status: st_ok, rdata: reply};
      reply_bad_parity: exp = '{status: st_parity_err, rdata: reply};
      reply_low_stop:   exp = '{status: st_frame_err, rdata: reply};
      default:
      begin
        exp = '{status: st_timeout, rdata: 8'h00};
        check_window({name, " ack delay"}, RSP_TIMEOUT_BITS * CPB,
                     RSP_TIMEOUT_BITS * CPB + 2 * CPB, ack_cyc - (f0 + FRAME_CLKS));
      end
    endcase
    check_rsp(name, exp, rsp);
    drop_req(name);
  endtask

  initial
  begin
    cmd_req = 1'b0;
    cmd     = '0;
    rx      = 1'b1;
    reset_values();
    write_cycle("write", 7'h15, 0);
    read_cycle("read", 7'h2a, reply_good);
    read_cycle("read bad parity", 7'h31, reply_bad_parity);
    read_cycle("read low stop", 7'h0c, reply_low_stop);
    read_cycle("read no reply", 7'h7f, reply_none);
    write_cycle("write held", 7'h40, 50);
    read_cycle("read after hold", 7'h03, reply_good);
    $display("checks: %0d, value mismatches: %0d, other failures: %0d",
             checks, mismatches, faults);
    if (mismatches == 0 && faults == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* uart_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top
  import uart_pkg::*, cmd_pkg::*;
#(
  parameter int CLKS_PER_BIT     = 434,
  parameter int PARITY_ODD       = 0,
  parameter int GAP_BITS         = 15,
  parameter int RSP_TIMEOUT_BITS = 40
) (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_req,
  input  cmd_t cmd,
  output logic cmd_ack,
  output rsp_t rsp,
  input  logic rx,
  output logic tx
);

  logic        tx_start;
  logic [7:0]  tx_byte;
  logic        tx_busy;
  logic        rx_arm;
  logic        rx_done;
  uart_frame_t rx_frame;

  cmd_master #(
    .CLKS_PER_BIT    (CLKS_PER_BIT),
    .GAP_BITS        (GAP_BITS),
    .RSP_TIMEOUT_BITS(RSP_TIMEOUT_BITS)
  ) i_master (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rsp     (rsp),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx_busy (tx_busy),
    .rx_arm  (rx_arm),
    .rx_done (rx_done),
    .rx_frame(rx_frame)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .PARITY_ODD  (PARITY_ODD)
  ) i_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx_busy (tx_busy),
    .tx      (tx)
  );

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .PARITY_ODD  (PARITY_ODD)
  ) i_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_arm  (rx_arm),
    .rx_done (rx_done),
    .rx_frame(rx_frame)
  );

endmodule

`default_nettype wire

/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // receive side results
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    rx_err_none   = 2'd0,
    rx_err_parity = 2'd1,
    rx_err_frame  = 2'd2  // stop bit sampled low
  } rx_error_e;

  typedef struct packed {
    logic [7:0] data;
    rx_error_e  err;
  } uart_frame_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line parity
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // even parity unless odd is set, so the frame's ones count comes out right
  function automatic logic parity_bit(input logic [7:0] data, input logic odd);
    parity_bit = (^data) ^ odd;
  endfunction

endpackage

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter int PARITY_ODD   = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  input  logic        rx_arm,
  output logic        rx_done,
  output uart_frame_t rx_frame
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int HALF  = CLKS_PER_BIT / 2;

  typedef enum logic [2:0] {
    s_hunt,
    s_start,
    s_data,
    s_parity,
    s_stop
  } state_e;

  state_e           state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       data_sh;
  logic             par_err;
  logic             mid_start;
  logic             mid_bit;

  // from the falling edge, half a bit reaches the middle of the start bit
  assign mid_start = clk_cnt == CNT_W'(HALF - 1);
  assign mid_bit   = clk_cnt == CNT_W'(CLKS_PER_BIT - 1);  // a full bit on from the last sample

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= s_hunt;
      clk_cnt <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_arm)
      begin
        state <= s_hunt;  // disarming drops whatever was in flight
      end
      else
      begin
        case (state)
          s_hunt:
          begin
            clk_cnt <= '0;
            bit_idx <= '0;
            if (!rx_sync)
              state <= s_start;
          end
          s_start:
          begin
            if (mid_start)
            begin
              clk_cnt <= '0;
              state   <= rx_sync ? s_hunt : s_data;  // a glitch is not a start bit
            end
            else
              clk_cnt <= clk_cnt + CNT_W'(1);
          end
          s_data:
          begin
            if (mid_bit)
            begin
              clk_cnt <= '0;
              bit_idx <= bit_idx + 3'd1;
              if (bit_idx == 3'd7)
                state <= s_parity;
            end
            else
              clk_cnt <= clk_cnt + CNT_W'(1);
          end
          s_parity:
          begin
            if (mid_bit)
            begin
              clk_cnt <= '0;
              state   <= s_stop;
            end
            else
              clk_cnt <= clk_cnt + CNT_W'(1);
          end
          s_stop:
          begin
            if (mid_bit)
            begin
              rx_done <= 1'b1;
              state   <= s_hunt;
            end
            else
              clk_cnt <= clk_cnt + CNT_W'(1);
          end
          default:
            state <= s_hunt;
        endcase
      end
    end
  end

  // data path, only looked at alongside rx_done
  always_ff @(posedge clk)
  begin
    if (state == s_data && mid_bit)
      data_sh <= {rx_sync, data_sh[7:1]};  // lsb arrives first
    if (state == s_parity && mid_bit)
      par_err <= rx_sync != parity_bit(data_sh, PARITY_ODD != 0);
    if (state == s_stop && mid_bit)
    begin
      rx_frame.data <= data_sh;
      if (par_err)
        rx_frame.err <= rx_err_parity;  // parity wins over a bad stop bit
      else if (!rx_sync)
        rx_frame.err <= rx_err_frame;
      else
        rx_frame.err <= rx_err_none;
    end
  end

  a_done_single : assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_done |=> !rx_done
  );

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 434,
  parameter int PARITY_ODD   = 0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx_busy,
  output logic       tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_idx;   // 0 is the start bit, 10 the stop bit
  logic [10:0]      shift_q;
  logic             bit_end;

  assign bit_end = clk_cnt == CNT_W'(CLKS_PER_BIT - 1);
  assign tx      = shift_q[0];  // the line is always the low end of the shifter

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      shift_q <= '1;  // idle high
    end
    else if (tx_start)
    begin
      tx_busy <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
      shift_q <= {1'b1, parity_bit(tx_byte, PARITY_ODD != 0), tx_byte, 1'b0};
    end
    else if (tx_busy)
    begin
      if (bit_end)
      begin
        clk_cnt <= '0;
        shift_q <= {1'b1, shift_q[10:1]};  // ones fill in behind the stop bit
        if (bit_idx == 4'd10)
          tx_busy <= 1'b0;
        else
          bit_idx <= bit_idx + 4'd1;
      end
      else
      begin
        clk_cnt <= clk_cnt + CNT_W'(1);
      end
    end
  end

  // the sequencer must wait for the whole frame, gap included, before the next byte
  a_no_start_when_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy
  );

endmodule

`default_nettype wire
